/* design/frameBuffer.sv */
// two-bank pixel memory with one write port and one registered read port
module frameBuffer (
    input logic clk,
    fbWrIf.mem  wr,
    fbRdIf.mem  rd
);
    import gpuPkg::*;

    localparam int depth = 2 * frameSize;  // both banks back to back

    pixelT mem [depth];
    logic [$clog2(depth)-1:0] wrIndex;
    logic [$clog2(depth)-1:0] rdIndex;

    // bank bit on top of the pixel index
    assign wrIndex = {wr.wrBank, wr.wrAddr};
    assign rdIndex = {rd.rdBank, rd.rdAddr};

    always_ff @(posedge clk)
    begin
        if (wr.wrEn)
            mem[wrIndex] <= wr.wrData;
    end

    // output holds its value while rdEn is low
    always_ff @(posedge clk)
    begin
        if (rd.rdEn)
            rd.rdData <= mem[rdIndex];
    end

endmodule

/* design/gpuIf.sv */
// draw command, frame buffer write and frame buffer read interfaces
interface fillCmdIf;
    import gpuPkg::*;

    logic [31:0] xPos;
    logic [31:0] yPos;
    pixelT       color;
    logic [31:0] len;
    logic        start;      // one cycle pulse
    logic        backBank;   // bank the engine draws into
    logic        busy;
    logic        done;       // one cycle pulse per finished draw

    modport regs   (output xPos, yPos, color, len, start, backBank, input busy, done);
    modport engine (input xPos, yPos, color, len, start, backBank, output busy, done);
endinterface

interface fbWrIf;
    import gpuPkg::*;

    logic   wrEn;
    logic   wrBank;
    fbAddrT wrAddr;
    pixelT  wrData;

    modport writer (output wrEn, wrBank, wrAddr, wrData);
    modport mem    (input wrEn, wrBank, wrAddr, wrData);
endinterface

interface fbRdIf;
    import gpuPkg::*;

    logic   rdEn;
    logic   rdBank;
    fbAddrT rdAddr;
    pixelT  rdData;          // valid one cycle after rdEn

    modport reader (output rdEn, rdBank, rdAddr, input rdData);
    modport mem    (input rdEn, rdBank, rdAddr, output rdData);
endinterface

/* design/gpuPkg.sv */
// frame geometry, pixel and address types, register map and AXI response codes
package gpuPkg;

    localparam int frameWidth  = 16;                      // pixels per row
    localparam int frameHeight = 8;                       // rows per frame
    localparam int frameSize   = frameWidth * frameHeight;

    typedef logic [23:0] pixelT;                          // 8 bits each of R, G, B
    typedef logic [$clog2(frameSize)-1:0] fbAddrT;        // row * frameWidth + column

    // word index of each register, byte address divided by 4
    localparam int numRegs = 8;
    localparam logic [2:0] regXPos      = 3'd0;
    localparam logic [2:0] regYPos      = 3'd1;
    localparam logic [2:0] regColor     = 3'd2;
    localparam logic [2:0] regLen       = 3'd3;
    localparam logic [2:0] regCtrl      = 3'd4;           // bit 0 requests a draw
    localparam logic [2:0] regStatus    = 3'd5;           // bit 0 busy
    localparam logic [2:0] regPingPong  = 3'd6;           // bit 0 front bank
    localparam logic [2:0] regDoneCount = 3'd7;

    typedef logic [4:0] regAddrT;                         // AXI4-Lite byte address

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

endpackage

/* design/gpuRegs.sv */
// AXI4-Lite register file with draw start pulse, status readback and done counter
module gpuRegs (
    input  logic            clk,
    input  logic            rstn,
    input  gpuPkg::regAddrT awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  logic [31:0]     wdata,
    input  logic [3:0]      wstrb,
    input  logic            wvalid,
    output logic            wready,
    output logic [1:0]      bresp,
    output logic            bvalid,
    input  logic            bready,
    input  gpuPkg::regAddrT araddr,
    input  logic            arvalid,
    output logic            arready,
    output logic [31:0]     rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  logic            rready,
    fillCmdIf.regs          cmd
);
    import gpuPkg::*;

    logic [31:0] xPosReg;
    logic [31:0] yPosReg;
    logic [31:0] colorReg;
    logic [31:0] lenReg;
    logic [31:0] pingPongReg;
    logic [31:0] doneCount;
    logic [31:0] readWord;
    logic        wrFire;
    logic        rdFire;
    logic [$clog2(numRegs)-1:0] wrIdx;
    logic [$clog2(numRegs)-1:0] rdIdx;

    function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0]  strb);
        logic [31:0] result;
        result = oldWord;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                result[8*b +: 8] = newWord[8*b +: 8];
        end
        return result;
    endfunction

    assign wrIdx   = awaddr[4:2];
    assign rdIdx   = araddr[4:2];
    assign wrFire  = awvalid & wvalid & ~bvalid;  // both channels, no response pending
    assign rdFire  = arvalid & ~rvalid;
    assign awready = wrFire;
    assign wready  = wrFire;
    assign arready = rdFire;
    assign bresp   = respOkay;
    assign rresp   = respOkay;

    assign cmd.xPos     = xPosReg;
    assign cmd.yPos     = yPosReg;
    assign cmd.color    = colorReg[23:0];
    assign cmd.len      = lenReg;
    assign cmd.backBank = ~pingPongReg[0];        // draw into the bank not shown

    always_comb
    begin
        case (rdIdx)
            regXPos:      readWord = xPosReg;
            regYPos:      readWord = yPosReg;
            regColor:     readWord = colorReg;
            regLen:       readWord = lenReg;
            regStatus:    readWord = {31'b0, cmd.busy};
            regPingPong:  readWord = pingPongReg;
            regDoneCount: readWord = doneCount;
            default:      readWord = '0;          // regCtrl reads as zero
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            xPosReg     <= '0;
            yPosReg     <= '0;
            colorReg    <= '0;
            lenReg      <= '0;
            pingPongReg <= '0;
            doneCount   <= '0;
            cmd.start   <= 1'b0;
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
        end
        else
        begin
            cmd.start <= 1'b0;
            if (wrFire)
            begin
                case (wrIdx)
                    regXPos:     xPosReg     <= mergeBytes(xPosReg, wdata, wstrb);
                    regYPos:     yPosReg     <= mergeBytes(yPosReg, wdata, wstrb);
                    regColor:    colorReg    <= mergeBytes(colorReg, wdata, wstrb);
                    regLen:      lenReg      <= mergeBytes(lenReg, wdata, wstrb);
                    regPingPong: pingPongReg <= mergeBytes(pingPongReg, wdata, wstrb);
                    regCtrl:     cmd.start   <= wstrb[0] & wdata[0] & ~cmd.busy;
                    default:     ;                // status and count ignore writes
                endcase
            end

            if (wrFire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rdFire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            if (cmd.done)
                doneCount <= doneCount + 32'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rdFire)
            rdata <= readWord;
    end

endmodule

/* design/gpuTop.sv */
// graphics peripheral top with AXI4-Lite slave and pixel stream ports
module gpuTop (
    input  logic            clk,
    input  logic            rstn,
    input  gpuPkg::regAddrT awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  logic [31:0]     wdata,
    input  logic [3:0]      wstrb,
    input  logic            wvalid,
    output logic            wready,
    output logic [1:0]      bresp,
    output logic            bvalid,
    input  logic            bready,
    input  gpuPkg::regAddrT araddr,
    input  logic            arvalid,
    output logic            arready,
    output logic [31:0]     rdata,
    output logic [1:0]      rresp,
    output logic            rvalid,
    input  logic            rready,
    output gpuPkg::pixelT   pixelData,
    output logic            pixelLast,
    output logic            pixelValid,
    input  logic            pixelReady
);

    fillCmdIf cmdBus ();
    fbWrIf    wrBus ();
    fbRdIf    rdBus ();

    gpuRegs regs_i (
        .clk, .rstn,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .cmd (cmdBus.regs)
    );

    lineFill fill_i (.clk, .rstn, .cmd (cmdBus.engine), .wr (wrBus.writer));

    frameBuffer fb_i (.clk, .wr (wrBus.mem), .rd (rdBus.mem));

    scanOut scan_i (
        .clk, .rstn,
        .frontBank (~cmdBus.backBank),  // shown bank is the one not drawn into
        .rd        (rdBus.reader),
        .pixelData, .pixelLast, .pixelValid, .pixelReady
    );

endmodule

/* design/lineFill.sv */
// line-fill engine writing a clipped horizontal run into the back bank
module lineFill (
    input  logic     clk,
    input  logic     rstn,
    fillCmdIf.engine cmd,
    fbWrIf.writer    wr
);
    import gpuPkg::*;

    logic [31:0] rowRoom;
    logic [4:0]  runLen;
    logic [4:0]  remaining;
    fbAddrT      startAddr;
    fbAddrT      curAddr;
    pixelT       colorQ;
    logic        bankQ;
    logic        busyQ;
    logic        doneQ;
    logic        accept;

    // room left in the row from xPos, at most frameWidth
    assign rowRoom   = 32'(frameWidth) - cmd.xPos;
    assign startAddr = fbAddrT'(cmd.yPos * frameWidth + cmd.xPos);
    assign accept    = cmd.start & ~busyQ;

    always_comb
    begin
        runLen = '0;
        if (cmd.xPos < frameWidth && cmd.yPos < frameHeight && cmd.len != 0)
            runLen = (cmd.len < rowRoom) ? cmd.len[4:0] : rowRoom[4:0];
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            busyQ     <= 1'b0;
            doneQ     <= 1'b0;
            remaining <= '0;
        end
        else
        begin
            doneQ <= 1'b0;
            if (accept)
            begin
                remaining <= runLen;
                busyQ     <= (runLen != 0);
                doneQ     <= (runLen == 0);   // empty run finishes at once
            end
            else if (busyQ)
            begin
                remaining <= remaining - 5'd1;
                if (remaining == 5'd1)
                begin
                    busyQ <= 1'b0;
                    doneQ <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            curAddr <= startAddr;
            colorQ  <= cmd.color;
            bankQ   <= cmd.backBank;
        end
        else if (busyQ)
            curAddr <= curAddr + 1'b1;    // next pixel of the run
    end

    assign cmd.busy  = busyQ;
    assign cmd.done  = doneQ;
    assign wr.wrEn   = busyQ;
    assign wr.wrBank = bankQ;
    assign wr.wrAddr = curAddr;
    assign wr.wrData = colorQ;

endmodule

/* design/scanOut.sv */
// raster scan of the front bank into a valid/ready pixel stream
module scanOut (
    input  logic          clk,
    input  logic          rstn,
    input  logic          frontBank,
    fbRdIf.reader         rd,
    output gpuPkg::pixelT pixelData,
    output logic          pixelLast,
    output logic          pixelValid,
    input  logic          pixelReady
);
    import gpuPkg::*;

    fbAddrT addrQ;
    logic   bankQ;
    logic   pending;     // rdData holds a pixel not yet taken
    logic   pendLast;
    logic   loadOut;

    assign loadOut   = pending & (~pixelValid | pixelReady);
    assign rd.rdEn   = ~pending | loadOut;                      // read only into a free slot
    assign rd.rdAddr = addrQ;
    assign rd.rdBank = (addrQ == '0) ? frontBank : bankQ;   // new bank at frame start

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            addrQ      <= '0;
            bankQ      <= 1'b0;
            pending    <= 1'b0;
            pendLast   <= 1'b0;
            pixelValid <= 1'b0;
            pixelLast  <= 1'b0;
        end
        else
        begin
            if (rd.rdEn)
            begin
                addrQ    <= (addrQ == fbAddrT'(frameSize - 1)) ? '0 : addrQ + 1'b1;
                pendLast <= (addrQ == fbAddrT'(frameSize - 1));
                if (addrQ == '0)
                    bankQ <= frontBank;
            end
            pending <= rd.rdEn | (pending & ~loadOut);

            if (loadOut)
            begin
                pixelValid <= 1'b1;
                pixelLast  <= pendLast;
            end
            else if (pixelReady)
                pixelValid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (loadOut)
            pixelData <= rd.rdData;
    end

endmodule

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator from tb.f and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f tb.f --top-module gpuTb -Mdir obj_dir -o gpuSim
./obj_dir/gpuSim

/* tb.f */
design/gpuPkg.sv
design/gpuIf.sv
design/gpuRegs.sv
design/lineFill.sv
design/frameBuffer.sv
design/scanOut.sv
design/gpuTop.sv
tests/gpuTop_chk.sv
tests/gpuTb.sv

/* tests/gpuTb.sv */
// testbench with stimulus tables, AXI tasks, frame reference model, compare tasks and watchdog
module gpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import gpuPkg::*;

    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] len;
        pixelT       color;
        logic        flip;      // toggle the front bank after the draw
    } drawT;

    typedef struct packed {
        regAddrT     addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] want;
    } rbT;

    localparam int numDraws = 24;
    localparam int watchdogCycles = numDraws * 2000 + 5000;

    logic        clk;
    logic        rstn;
    regAddrT     awaddr;
    regAddrT     araddr;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    pixelT       pixelData;
    logic        pixelLast, pixelValid, pixelReady;

    drawT  draws [numDraws];
    pixelT model [2][frameSize];      // expected bank contents
    bit    known [2][frameSize];      // pixels written since reset
    pixelT curFrame [frameSize];
    pixelT lastFrame [frameSize];     // last complete frame seen on the stream
    int    framesSeen = 0;

    // byte merge results follow the wstrb lanes
    rbT rbTable [11] = '{
        '{5'h00, 32'hDEADBEEF, 4'hF, 32'hDEADBEEF},
        '{5'h00, 32'h11223344, 4'h5, 32'hDE22BE44},
        '{5'h04, 32'hCAFEF00D, 4'hC, 32'hCAFE0000},
        '{5'h08, 32'h00ABCDEF, 4'hF, 32'h00ABCDEF},
        '{5'h08, 32'hFFFFFFFF, 4'h8, 32'hFFABCDEF},
        '{5'h0C, 32'h12345678, 4'h3, 32'h00005678},
        '{5'h10, 32'h00000002, 4'hF, 32'h00000000},   // ctrl without the draw bit
        '{5'h14, 32'hFFFFFFFF, 4'hF, 32'h00000000},
        '{5'h1C, 32'h12345678, 4'hF, 32'h00000000},
        '{5'h18, 32'hA5A5A5A4, 4'h1, 32'h000000A4},
        '{5'h18, 32'h00000000, 4'hF, 32'h00000000}
    };

    gpuTop dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkPixel(input string name, input pixelT want, input pixelT got);
        if (got !== want)
        begin
            $display("ERROR %s expected 0x%h got 0x%h", name, want, got);
            stopWithFailure();
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] want, input logic [31:0] got);
        if (got !== want)
        begin
            $display("ERROR %s expected 0x%h got 0x%h", name, want, got);
            stopWithFailure();
        end
    endtask

    task automatic checkResp(input string name, input logic [1:0] want, input logic [1:0] got);
        if (got !== want)
        begin
            $display("ERROR %s expected 0x%h got 0x%h", name, want, got);
            stopWithFailure();
        end
    endtask

    task automatic checkFlag(input string name, input logic want, input logic got);
        if (got !== want)
        begin
            $display("ERROR %s expected 0x%h got 0x%h", name, want, got);
            stopWithFailure();
        end
    endtask

    function automatic regAddrT regAddr(input logic [2:0] idx);
        return {idx, 2'b00};
    endfunction

    // number of pixels a draw writes after clipping to the row and frame
    function automatic int runLength(input drawT d);
        if (d.y >= frameHeight || d.x >= frameWidth || d.len == 0)
            return 0;
        return (d.len < frameWidth - d.x) ? int'(d.len) : frameWidth - int'(d.x);
    endfunction

    // entered and left on a falling edge
    task automatic axiWrite(input regAddrT addr, input logic [31:0] data, input logic [3:0] strb);
        logic accepted;
        awaddr   = addr;
        wdata    = data;
        wstrb    = strb;
        awvalid  = 1'b1;
        wvalid   = 1'b1;
        accepted = 1'b0;
        while (!accepted)
        begin
            #1;                                // readies follow the valids
            accepted = awready;
            if (accepted)
                checkFlag("wready", 1'b1, wready);
            @(negedge clk);
        end
        checkFlag("bvalid", 1'b1, bvalid);     // one cycle after the accept
        checkFlag("awready", 1'b0, awready);
        checkFlag("wready", 1'b0, wready);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        checkResp("bresp", respOkay, bresp);
    endtask

    task automatic axiRead(input regAddrT addr, output logic [31:0] data);
        logic accepted;
        araddr   = addr;
        arvalid  = 1'b1;
        accepted = 1'b0;
        while (!accepted)
        begin
            #1;
            accepted = arready;
            @(negedge clk);
        end
        checkFlag("rvalid", 1'b1, rvalid);
        checkFlag("arready", 1'b0, arready);
        arvalid = 1'b0;
        data    = rdata;
        checkResp("rresp", respOkay, rresp);
    endtask

    // the frame in flight may still come from the old bank
    task automatic checkFrontFrame(input logic front);
        int target;
        target = framesSeen + 3;
        wait (framesSeen >= target);
        for (int i = 0; i < frameSize; i++)
        begin
            if (known[front][i])
                checkPixel($sformatf("pixelData[%0d]", i), model[front][i], lastFrame[i]);
        end
    endtask

    // pixel sink with random back-pressure
    initial
    begin
        int   pos;
        logic readyNext;
        pos        = 0;
        pixelReady = 1'b0;
        forever
        begin
            @(negedge clk);
            readyNext  = ($urandom % 4) != 0;
            pixelReady = readyNext;
            if (pixelValid && readyNext)          // transfer at the next rising edge
            begin
                checkFlag("pixelLast", pos == frameSize - 1, pixelLast);
                curFrame[pos] = pixelData;
                if (pos == frameSize - 1)
                begin
                    lastFrame = curFrame;
                    pos = 0;
                    framesSeen++;
                end
                else
                    pos++;
            end
        end
    end

    initial
    begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", watchdogCycles);
        stopWithFailure();
    end

    initial
    begin
        logic [31:0] word;
        logic        ping;
        int          n;
        int          base;
        void'($urandom(32'he5fe9a32));
        rstn    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        ping    = 1'b0;

        for (int r = 0; r < 16; r++)              // whole rows, bank 1 then bank 0
            draws[r] = '{32'd0, 32'(r % frameHeight), 32'd16,
                         pixelT'(24'h2C1B0A * (r + 1)), (r % frameHeight) == frameHeight - 1};
        draws[16] = '{32'd3, 32'd2, 32'd5, 24'hA1B2C3, 1'b0};
        draws[17] = '{32'd12, 32'd5, 32'd10, 24'h5A5A00, 1'b1};   // clipped at row end
        draws[18] = '{32'd0, 32'd9, 32'd4, 24'h00FF00, 1'b0};     // below the frame
        draws[19] = '{32'd7, 32'd3, 32'd0, 24'h123456, 1'b0};
        draws[20] = '{32'd15, 32'd7, 32'd1, 24'hFFFFFF, 1'b1};
        draws[21] = '{32'd1, 32'd4, 32'd12, 24'h0C0C0C, 1'b0};
        draws[22] = '{32'd20, 32'd1, 32'd3, 24'h0000EE, 1'b1};    // right of the frame
        draws[23] = '{32'd6, 32'd0, 32'd40, 24'hABCDEF, 1'b1};

        repeat (4) @(negedge clk);
        rstn = 1'b1;

        foreach (rbTable[i])
        begin
            bready = 1'b0;                        // responses wait a few cycles
            axiWrite(rbTable[i].addr, rbTable[i].data, rbTable[i].strb);
            repeat (1 + $urandom % 3) @(negedge clk);
            bready = 1'b1;
            rready = 1'b0;
            axiRead(rbTable[i].addr, word);
            repeat (1 + $urandom % 3) @(negedge clk);
            rready = 1'b1;
            checkWord($sformatf("rdata at 0x%h", rbTable[i].addr), rbTable[i].want, word);
        end

        foreach (draws[i])
        begin
            n = runLength(draws[i]);
            axiWrite(regAddr(regXPos), draws[i].x, 4'hF);
            axiWrite(regAddr(regYPos), draws[i].y, 4'hF);
            axiWrite(regAddr(regColor), {8'h00, draws[i].color}, 4'hF);
            axiWrite(regAddr(regLen), draws[i].len, 4'hF);
            axiWrite(regAddr(regCtrl), 32'd1, 4'hF);
            @(negedge clk);                        // busy rises a cycle after start
            axiRead(regAddr(regStatus), word);
            checkWord("regStatus", {31'b0, n > 0}, word);
            if (n >= 8)
                axiWrite(regAddr(regCtrl), 32'd1, 4'hF);   // lands while busy
            while (word[0])
                axiRead(regAddr(regStatus), word);
            axiRead(regAddr(regDoneCount), word);
            checkWord("regDoneCount", 32'(i + 1), word);

            base = int'(draws[i].y) * frameWidth + int'(draws[i].x);
            for (int k = 0; k < n; k++)
            begin
                model[~ping][base + k] = draws[i].color;
                known[~ping][base + k] = 1'b1;
            end
            if (draws[i].flip)
            begin
                ping = ~ping;
                axiWrite(regAddr(regPingPong), {31'b0, ping}, 4'hF);
            end
            checkFrontFrame(ping);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tests/gpuTop_chk.sv */
// handshake hold and payload stability assertions bound to the top level
module gpuTopChk (
    input logic          clk,
    input logic          rstn,
    input logic          bvalid,
    input logic          bready,
    input logic          rvalid,
    input logic          rready,
    input logic [31:0]   rdata,
    input logic          pixelValid,
    input logic          pixelReady,
    input gpuPkg::pixelT pixelData,
    input logic          pixelLast
);
    timeunit 1ns;
    timeprecision 100ps;

    bHold: assert property (@(posedge clk) disable iff (!rstn) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    rHold: assert property (@(posedge clk) disable iff (!rstn) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");
    rStable: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> $stable(rdata))
        else $error("rdata changed while stalled");
    pixHold: assert property (@(posedge clk) disable iff (!rstn)
        pixelValid && !pixelReady |=> pixelValid)
        else $error("pixelValid dropped before pixelReady");
    pixStable: assert property (@(posedge clk) disable iff (!rstn)
        pixelValid && !pixelReady |=> $stable({pixelData, pixelLast}))
        else $error("pixel payload changed while stalled");

endmodule

bind gpuTop gpuTopChk chk_i (
    .clk (clk), .rstn (rstn), .bvalid (bvalid), .bready (bready),
    .rvalid (rvalid), .rready (rready), .rdata (rdata),
    .pixelValid (pixelValid), .pixelReady (pixelReady),
    .pixelData (pixelData), .pixelLast (pixelLast)
);
